// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := tb_mma
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS      := TEST OK

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) bench/tb_mma_cases.svh

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_mma_cases.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Case table for tb_mma, included inside the module after the imports
// Expected codes must agree with the dims of the previous good loads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef TB_MMA_CASES_SVH
`define TB_MMA_CASES_SVH

typedef struct packed {
    dim_t        a_rows;                        // Dims sent for A, may be out of range
    dim_t        a_cols;
    dim_t        b_rows;
    dim_t        b_cols;
    word_t       seed;                          // Element stream seed
    logic        bp;                            // Random tx_ready_i low
    logic        stall;                         // Truncated load before the case
    proto_code_e exp_a;                         // Load A response
    proto_code_e exp_b;
    proto_code_e exp_mul;                       // Multiply response
} case_t;

localparam int NUM_CASES = 11;

// A rows, A cols, B rows, B cols, seed, bp, stall, A rsp, B rsp, multiply rsp
localparam case_t CASES [NUM_CASES] = '{
    '{8'd2, 8'd3, 8'd3, 8'd2, 32'h0000_0001, 1'b0, 1'b0, RSP_ACK, RSP_ACK, RSP_DONE},
    '{8'd3, 8'd3, 8'd3, 8'd4, 32'h0000_0002, 1'b0, 1'b0, RSP_ACK, RSP_ACK, RSP_DONE},
    '{8'd2, 8'd4, 8'd3, 8'd2, 32'h0000_0003, 1'b0, 1'b0, RSP_ACK, RSP_ACK, RSP_ERR},
    '{8'd4, 8'd5, 8'd5, 8'd3, 32'h0000_0004, 1'b1, 1'b0, RSP_ACK, RSP_ACK, RSP_DONE},
    '{8'd1, 8'd2, 8'd3, 8'd1, 32'h0000_0005, 1'b1, 1'b0, RSP_ACK, RSP_ACK, RSP_ERR},
    '{8'd1, 8'd1, 8'd1, 8'd1, 32'h0000_0006, 1'b0, 1'b1, RSP_ACK, RSP_ACK, RSP_DONE},
    '{8'd0, 8'd4, 8'd9, 8'd2, 32'h0000_0007, 1'b0, 1'b0, RSP_ERR, RSP_ERR, RSP_DONE},
    '{8'd8, 8'd8, 8'd8, 8'd8, 32'h0000_0008, 1'b1, 1'b0, RSP_ACK, RSP_ACK, RSP_DONE},
    '{8'd1, 8'd8, 8'd8, 8'd1, 32'h0000_0009, 1'b1, 1'b0, RSP_ACK, RSP_ACK, RSP_DONE},
    '{8'd8, 8'd1, 8'd1, 8'd8, 32'h0000_000A, 1'b0, 1'b0, RSP_ACK, RSP_ACK, RSP_DONE},
    '{8'd9, 8'd1, 8'd3, 8'd0, 32'h0000_000B, 1'b1, 1'b0, RSP_ERR, RSP_ERR, RSP_DONE}
};

`endif

// File: bench/tb_mma.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for mma_top. Byte-level host model with a software product
// Stops at the first mismatch. Bytes are sent three cycles apart
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_mma
    import mma_proto_pkg::*;
    import mma_core_pkg::*;
;

    localparam int    MAX_DIM    = 8;
    localparam int    RX_TIMEOUT = 200;
    localparam int    RSP_WAIT   = 3000;        // Cycles without a new byte
    localparam word_t LCG_SEED   = 32'h11929626;

    `include "tb_mma_cases.svh"

    logic  CLK100MHZ = 1'b0;
    logic  reset_i;
    byte_t rx_byte_i;
    logic  rx_valid_i;
    byte_t tx_byte_o;
    logic  tx_valid_o;
    logic  tx_ready_i;
    logic  bp_on;                               // Back-pressure for the current case
    byte_t rx_q [$];                            // Bytes taken from the DUT

    word_t model_a [MAX_DIM*MAX_DIM];           // Host view of the stores
    word_t model_b [MAX_DIM*MAX_DIM];
    word_t model_r [MAX_DIM*MAX_DIM];
    int    am_rows = 0, am_cols = 0, bm_rows = 0, bm_cols = 0, rm_rows = 0, rm_cols = 0;

    mma_top #(.MAX_DIM(MAX_DIM), .RX_TIMEOUT_CYCLES(RX_TIMEOUT)) i_dut (
        .CLK100MHZ(CLK100MHZ), .reset_i(reset_i),
        .rx_byte_i(rx_byte_i), .rx_valid_i(rx_valid_i),
        .tx_byte_o(tx_byte_o), .tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i)
    );

    always #5 CLK100MHZ = ~CLK100MHZ;           // 100 MHz

    function automatic word_t lcg_next(word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Generous cycle bound over the whole table
    function automatic int unsigned watchdog_cycles();
        int unsigned total;
        int unsigned ar, ac, br, bc;
        total = 1000;
        foreach (CASES[i]) begin
            ar = int'(CASES[i].a_rows);
            ac = int'(CASES[i].a_cols);
            br = int'(CASES[i].b_rows);
            bc = int'(CASES[i].b_cols);
            total += 3 * (18 + 4 * ar * ac + 4 * br * bc); // Receive bytes
            total += CASES[i].stall ? RX_TIMEOUT + 60 : 0;
            total += MAX_DIM * MAX_DIM * (MAX_DIM + 6);    // Worst multiply
            total += 6 * (8 + 4 * MAX_DIM * MAX_DIM);      // Read back under stalls
            total += 100;
        end
        return 2 * total;
    endfunction

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_code(string sig, proto_code_e got, proto_code_e exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED t=%0t %s: got 0x%02h, expected 0x%02h",
                                    $time, sig, got, exp));
        end
    endtask

    task automatic check_word(string sig, word_t got, word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("CHECK FAILED t=%0t %s: got 0x%08h, expected 0x%08h",
                                    $time, sig, got, exp));
        end
    endtask

    task automatic send_byte(byte_t b);
        @(posedge CLK100MHZ);
        rx_byte_i  <= b;
        rx_valid_i <= 1'b1;
        @(posedge CLK100MHZ);
        rx_valid_i <= 1'b0;
        @(posedge CLK100MHZ);                   // Second idle cycle follows in next call
    endtask

    task automatic send_word(word_t w);
        for (int i = 3; i >= 0; i--) send_byte(w[8*i +: 8]); // MSB first
    endtask

    task automatic wait_bytes(int n);
        int idle;
        int seen;
        idle = 0;
        seen = rx_q.size();
        while (rx_q.size() < n) begin
            @(posedge CLK100MHZ);
            idle = (rx_q.size() != seen) ? 0 : idle + 1; // Restart on progress
            seen = rx_q.size();
            if (idle > RSP_WAIT) begin
                stop_on_error($sformatf("No response byte from the DUT for %0d cycles at %0t",
                                        RSP_WAIT, $time));
            end
        end
    endtask

    task automatic expect_code(string sig, proto_code_e exp);
        wait_bytes(1);
        check_code(sig, proto_code_e'(rx_q.pop_front()), exp);
    endtask

    task automatic expect_word(string sig, word_t exp);
        word_t w;
        w = '0;
        wait_bytes(4);
        repeat (4) w = {w[23:0], rx_q.pop_front()};
        check_word(sig, w, exp);
    endtask

    // DUT back in IDLE and nothing more on the wire
    task automatic settle_idle();
        repeat (8) @(posedge CLK100MHZ);
        if (rx_q.size() != 0) begin
            stop_on_error($sformatf("DUT sent %0d extra byte(s) after its response at %0t",
                                    rx_q.size(), $time));
        end
    endtask

    task automatic load_matrix(logic is_b, dim_t rows, dim_t cols, word_t seed,
                               proto_code_e exp);
        word_t vals [MAX_DIM*MAX_DIM];
        word_t st;
        int    n;
        n  = int'(rows) * int'(cols);
        st = LCG_SEED ^ seed;
        send_byte(is_b ? CMD_RX_B : CMD_RX_A);
        send_word(word_t'(rows));
        send_word(word_t'(cols));
        if (exp == RSP_ACK) begin               // No elements after a bad dim
            for (int i = 0; i < n; i++) begin
                st      = lcg_next(st);
                vals[i] = st;
                send_word(st);
            end
        end
        expect_code(is_b ? "load_b_rsp" : "load_a_rsp", exp);
        settle_idle();
        if (exp == RSP_ACK) begin
            for (int i = 0; i < n; i++) begin
                if (is_b) model_b[i] = vals[i];
                else      model_a[i] = vals[i];
            end
            if (is_b) begin
                bm_rows = int'(rows);
                bm_cols = int'(cols);
            end else begin
                am_rows = int'(rows);
                am_cols = int'(cols);
            end
        end
    endtask

    task automatic multiply(proto_code_e exp);
        word_t acc;
        send_byte(CMD_MUL);
        expect_code("mul_rsp", exp);
        settle_idle();
        if (exp == RSP_DONE) begin              // Row-column sums, mod 2^32
            for (int i = 0; i < am_rows; i++) begin
                for (int j = 0; j < bm_cols; j++) begin
                    acc = '0;
                    for (int k = 0; k < am_cols; k++) begin
                        acc += model_a[i*am_cols + k] * model_b[k*bm_cols + j];
                    end
                    model_r[i*bm_cols + j] = acc;
                end
            end
            rm_rows = am_rows;
            rm_cols = bm_cols;
        end
    endtask

    task automatic read_result();
        send_byte(CMD_TX_R);
        expect_word("r_rows", word_t'(rm_rows));
        expect_word("r_cols", word_t'(rm_cols));
        for (int i = 0; i < rm_rows * rm_cols; i++) begin
            expect_word($sformatf("r[%0d]", i), model_r[i]);
        end
        settle_idle();
    endtask

    task automatic run_case(int idx);
        case_t c;
        c = CASES[idx];
        bp_on <= c.bp;
        if (c.stall) begin                      // Receive A cut off mid word
            send_byte(CMD_RX_A);
            send_byte(8'h00);
            send_byte(8'h00);
            repeat (RX_TIMEOUT - 10) @(posedge CLK100MHZ); // Host silent, timer running
            if (rx_q.size() != 0) begin
                stop_on_error($sformatf("Response came before the receive timeout at %0t",
                                        $time));
            end
            expect_code("timeout_rsp", RSP_ERR);
            settle_idle();
        end
        load_matrix(1'b0, c.a_rows, c.a_cols, c.seed, c.exp_a);
        load_matrix(1'b1, c.b_rows, c.b_cols, ~c.seed, c.exp_b);
        multiply(c.exp_mul);
        read_result();
    endtask

    // Takes a byte when valid and ready meet at the coming edge
    always @(negedge CLK100MHZ) begin
        if (!reset_i && tx_valid_o && tx_ready_i) rx_q.push_back(tx_byte_o);
    end

    initial begin : ready_driver
        word_t rnd;
        rnd = LCG_SEED;
        tx_ready_i <= 1'b1;
        forever begin
            @(posedge CLK100MHZ);
            if (bp_on) begin
                rnd = lcg_next(rnd);
                tx_ready_i <= rnd[24];          // Upper bits, better spread
            end else begin
                tx_ready_i <= 1'b1;
            end
        end
    end

    initial begin : watchdog
        int unsigned limit;
        limit = watchdog_cycles();
        repeat (limit) @(posedge CLK100MHZ);
        stop_on_error($sformatf("Watchdog expired after %0d cycles, the run is stuck", limit));
    end

    initial begin
        reset_i    <= 1'b1;
        rx_byte_i  <= '0;
        rx_valid_i <= 1'b0;
        bp_on      <= 1'b0;
        repeat (8) @(posedge CLK100MHZ);
        reset_i <= 1'b0;
        @(posedge CLK100MHZ);
        if (tx_valid_o !== 1'b0) stop_on_error("tx_valid_o is not low after reset");
        repeat (2) @(posedge CLK100MHZ);
        for (int i = 0; i < NUM_CASES; i++) run_case(i);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/mac_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Unsigned integer MAC, wraps modulo 2^32
// Result valid three cycles after the pair marked last
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mac_unit
    import mma_proto_pkg::*;
(
    input  logic  CLK100MHZ,
    input  logic  reset_i,
    input  logic  valid_i,
    input  logic  first_i,
    input  logic  last_i,
    input  word_t a_i,
    input  word_t b_i,
    output word_t result_o,
    output logic  result_valid_o
);

    word_t prod_q;                              // Stage one
    logic  v1, first1, last1;
    word_t acc_q;                               // Stage two
    logic  done2;                               // Last product accumulated

    always_ff @(posedge CLK100MHZ) begin
        if (reset_i) begin
            v1             <= 1'b0;
            done2          <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            v1             <= valid_i;
            done2          <= v1 && last1;
            result_valid_o <= done2;
        end
        prod_q <= a_i * b_i;                    // Low 32 bits kept
        first1 <= first_i;
        last1  <= last_i;
        if (v1) acc_q <= (first1 ? '0 : acc_q) + prod_q;
        if (done2) result_o <= acc_q;           // Held while next element accumulates
    end

endmodule

`default_nettype wire

// File: rtl/matrix_store.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Single-port RAM of MAX_DIM squared words, read data a cycle late
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module matrix_store
    import mma_proto_pkg::*;
    import mma_core_pkg::*;
#(
    parameter int MAX_DIM = 8
) (
    input  logic  CLK100MHZ,
    input  logic  we_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    output word_t rdata_o
);

    localparam int DEPTH = MAX_DIM * MAX_DIM;
    localparam int AW    = $clog2(DEPTH);

    word_t mem [DEPTH];

    always_ff @(posedge CLK100MHZ) begin
        if (we_i) mem[addr_i[AW-1:0]] <= wdata_i;
        rdata_o <= mem[addr_i[AW-1:0]];         // Old data on a write cycle
    end

endmodule

`default_nettype wire

// File: rtl/mma_core_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Core types of the accelerator. addr_t covers MAX_DIM up to 16
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mma_core_pkg;

    typedef logic [7:0] dim_t;                  // Row or column count
    typedef logic [7:0] addr_t;                 // Store address, row-major

    typedef enum logic [3:0] {
        IDLE,                                   // Waiting for a command byte
        RX_DIM1,                                // Row count word
        RX_DIM2,                                // Column count word
        RX_DATA,                                // Element words
        MUL_CHECK,                              // Dimension agreement
        MUL_ISSUE,                              // Operand pairs into the MAC
        MUL_DRAIN,                              // Wait for the MAC result
        TX_DIM1,                                // Send R rows
        TX_DIM2,                                // Send R columns
        TX_DATA,                                // Send R elements
        SEND_RSP                                // Single response byte
    } seq_state_e;

endpackage

`default_nettype wire

// File: rtl/mma_proto_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host byte protocol of the matrix accelerator. Words go MSB first
// Response codes share the enum with the commands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mma_proto_pkg;

    typedef logic [7:0]  byte_t;                // One stream byte
    typedef logic [31:0] word_t;                // Element or dimension

    typedef enum byte_t {
        CMD_RX_A = 8'h01,                       // Load matrix A
        CMD_RX_B = 8'h02,                       // Load matrix B
        CMD_MUL  = 8'h03,                       // R = A x B
        CMD_TX_R = 8'h04,                       // Read back R
        RSP_DONE = 8'h05,                       // Multiply finished
        RSP_ACK  = 8'h06,                       // Matrix load complete
        RSP_ERR  = 8'hAA                        // Any failure
    } proto_code_e;

endpackage

`default_nettype wire

// File: rtl/mma_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Command FSM. Bytes outside IDLE and the receive states are dropped
// Dimensions must be 1..MAX_DIM. R dims change only on a good multiply
// Per element: K issue cycles, 3 drain cycles, 1 write cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mma_sequencer
    import mma_proto_pkg::*;
    import mma_core_pkg::*;
#(
    parameter int MAX_DIM = 8
) (
    input  logic  CLK100MHZ,
    input  logic  reset_i,
    input  byte_t rx_byte_i,
    input  logic  rx_valid_i,
    input  word_t word_i,
    input  logic  word_valid_i,
    input  logic  rx_timeout_i,
    output logic  word_expect_o,
    output logic  send_req_o,
    output word_t send_word_o,
    output logic  send_is_word_o,
    input  logic  send_done_i,
    output logic  store_a_we_o,
    output addr_t store_a_addr_o,
    output word_t store_a_wdata_o,
    input  word_t store_a_rdata_i,
    output logic  store_b_we_o,
    output addr_t store_b_addr_o,
    output word_t store_b_wdata_o,
    input  word_t store_b_rdata_i,
    output logic  store_r_we_o,
    output addr_t store_r_addr_o,
    output word_t store_r_wdata_o,
    input  word_t store_r_rdata_i,
    output logic  mac_valid_o,
    output logic  mac_first_o,
    output logic  mac_last_o,
    output word_t mac_a_o,
    output word_t mac_b_o,
    input  word_t mac_result_i,
    input  logic  mac_result_valid_i
);

    seq_state_e  state;
    proto_code_e rsp;                           // Code for SEND_RSP
    logic        sel_b;                         // Loading B, not A
    logic        dim_ok;                        // First dim was in range
    dim_t        rx_rows;                       // Held until the column count arrives
    dim_t        a_rows, a_cols, b_rows, b_cols, r_rows, r_cols;
    dim_t        row, col, k;                   // Element and inner index
    addr_t       lin;                           // Linear index for load, write-back, send
    addr_t       a_addr, b_addr, rx_last, r_last;
    logic        word_in_range;

    assign word_in_range = (word_i != '0) && (word_i <= word_t'(MAX_DIM));
    assign a_addr  = row * a_cols + k;          // A[row][k]
    assign b_addr  = k * b_cols + col;          // B[k][col]
    assign rx_last = sel_b ? b_rows * b_cols - 8'd1 : a_rows * a_cols - 8'd1;
    assign r_last  = r_rows * r_cols - 8'd1;

    always_ff @(posedge CLK100MHZ) begin
        if (reset_i) begin
            state       <= IDLE;
            mac_valid_o <= 1'b0;
            a_rows      <= '0;                  // Zero dims make a multiply fail
            a_cols      <= '0;
            b_rows      <= '0;
            b_cols      <= '0;
            r_rows      <= '0;
            r_cols      <= '0;
        end else begin
            mac_valid_o <= (state == MUL_ISSUE); // Operands arrive a cycle after address
            mac_first_o <= (k == '0);
            mac_last_o  <= (k == a_cols - 8'd1);
            case (state)
                IDLE: begin
                    lin <= '0;
                    row <= '0;
                    col <= '0;
                    k   <= '0;
                    if (rx_valid_i) begin
                        case (rx_byte_i)
                            CMD_RX_A: begin
                                sel_b <= 1'b0;
                                state <= RX_DIM1;
                            end
                            CMD_RX_B: begin
                                sel_b <= 1'b1;
                                state <= RX_DIM1;
                            end
                            CMD_MUL:  state <= MUL_CHECK;
                            CMD_TX_R: state <= TX_DIM1;
                            default:  state <= IDLE; // Unknown byte, stay put
                        endcase
                    end
                end
                RX_DIM1: begin
                    if (word_valid_i) begin
                        rx_rows <= word_i[7:0];
                        dim_ok  <= word_in_range;
                        state   <= RX_DIM2;
                    end
                end
                RX_DIM2: begin
                    if (word_valid_i) begin
                        if (dim_ok && word_in_range) begin
                            if (sel_b) begin
                                b_rows <= rx_rows;
                                b_cols <= word_i[7:0];
                            end else begin
                                a_rows <= rx_rows;
                                a_cols <= word_i[7:0];
                            end
                            state <= RX_DATA;
                        end else begin
                            rsp   <= RSP_ERR;   // Old matrix kept
                            state <= SEND_RSP;
                        end
                    end
                end
                RX_DATA: begin
                    if (word_valid_i) begin
                        lin <= lin + 8'd1;
                        if (lin == rx_last) begin
                            rsp   <= RSP_ACK;
                            state <= SEND_RSP;
                        end
                    end
                end
                MUL_CHECK: begin
                    if (a_cols == b_rows && a_cols != '0 && a_rows != '0 && b_cols != '0) begin
                        state <= MUL_ISSUE;
                    end else begin
                        rsp   <= RSP_ERR;
                        state <= SEND_RSP;
                    end
                end
                MUL_ISSUE: begin
                    if (k == a_cols - 8'd1) begin
                        k     <= '0;
                        state <= MUL_DRAIN;
                    end else begin
                        k <= k + 8'd1;
                    end
                end
                MUL_DRAIN: begin
                    if (mac_result_valid_i) begin // Write cycle of this element
                        lin   <= lin + 8'd1;
                        state <= MUL_ISSUE;
                        if (col == b_cols - 8'd1) begin
                            col <= '0;
                            row <= row + 8'd1;
                            if (row == a_rows - 8'd1) begin
                                r_rows <= a_rows;
                                r_cols <= b_cols;
                                rsp    <= RSP_DONE;
                                state  <= SEND_RSP;
                            end
                        end else begin
                            col <= col + 8'd1;
                        end
                    end
                end
                TX_DIM1: begin
                    if (send_done_i) state <= TX_DIM2;
                end
                TX_DIM2: begin
                    if (send_done_i) state <= (r_rows == '0) ? IDLE : TX_DATA; // No R yet
                end
                TX_DATA: begin
                    if (send_done_i) begin
                        lin <= lin + 8'd1;
                        if (lin == r_last) state <= IDLE;
                    end
                end
                SEND_RSP: begin
                    if (send_done_i) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
            if (word_expect_o && rx_timeout_i) begin // Stalled host overrides any state
                rsp   <= RSP_ERR;
                state <= SEND_RSP;
            end
        end
    end

    assign word_expect_o = state inside {RX_DIM1, RX_DIM2, RX_DATA};

    assign store_a_we_o    = (state == RX_DATA) && word_valid_i && !sel_b;
    assign store_a_addr_o  = (state == RX_DATA) ? lin : a_addr;
    assign store_a_wdata_o = word_i;
    assign store_b_we_o    = (state == RX_DATA) && word_valid_i && sel_b;
    assign store_b_addr_o  = (state == RX_DATA) ? lin : b_addr;
    assign store_b_wdata_o = word_i;

    // Read ahead on send_done so the next R element is ready when TX_DATA asks
    assign store_r_we_o    = (state == MUL_DRAIN) && mac_result_valid_i;
    assign store_r_addr_o  = (state == TX_DATA && send_done_i) ? lin + 8'd1 : lin;
    assign store_r_wdata_o = mac_result_i;

    assign mac_a_o = store_a_rdata_i;            // Aligned with the registered mac_valid_o
    assign mac_b_o = store_b_rdata_i;

    assign send_req_o     = state inside {TX_DIM1, TX_DIM2, TX_DATA, SEND_RSP};
    assign send_is_word_o = (state != SEND_RSP);

    always_comb begin
        case (state)
            TX_DIM1: send_word_o = {24'h0, r_rows};
            TX_DIM2: send_word_o = {24'h0, r_cols};
            TX_DATA: send_word_o = store_r_rdata_i;
            default: send_word_o = {24'h0, rsp}; // Low byte only
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/mma_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Matrix multiply accelerator on a parallel byte stream
// Host must leave at least two idle cycles between received bytes
// MAX_DIM above 16 overflows the 8-bit store address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mma_top
    import mma_proto_pkg::*;
    import mma_core_pkg::*;
#(
    parameter int MAX_DIM           = 8,
    parameter int RX_TIMEOUT_CYCLES = 2000
) (
    input  logic  CLK100MHZ,
    input  logic  reset_i,
    input  byte_t rx_byte_i,
    input  logic  rx_valid_i,
    output byte_t tx_byte_o,
    output logic  tx_valid_o,
    input  logic  tx_ready_i
);

    word_t word;                                // Assembled receive word
    logic  word_valid, rx_timeout, word_expect;
    logic  send_req, send_is_word, send_done;
    word_t send_word;
    logic  a_we, b_we, r_we;
    addr_t a_addr, b_addr, r_addr;
    word_t a_wdata, b_wdata, r_wdata;
    word_t a_rdata, b_rdata, r_rdata;
    logic  mac_valid, mac_first, mac_last;
    word_t mac_a, mac_b;
    word_t mac_result;
    logic  mac_result_valid;

    mma_sequencer #(.MAX_DIM(MAX_DIM)) u_sequencer (
        .CLK100MHZ(CLK100MHZ), .reset_i(reset_i),
        .rx_byte_i(rx_byte_i), .rx_valid_i(rx_valid_i),
        .word_i(word), .word_valid_i(word_valid),
        .rx_timeout_i(rx_timeout), .word_expect_o(word_expect),
        .send_req_o(send_req), .send_word_o(send_word),
        .send_is_word_o(send_is_word), .send_done_i(send_done),
        .store_a_we_o(a_we), .store_a_addr_o(a_addr),
        .store_a_wdata_o(a_wdata), .store_a_rdata_i(a_rdata),
        .store_b_we_o(b_we), .store_b_addr_o(b_addr),
        .store_b_wdata_o(b_wdata), .store_b_rdata_i(b_rdata),
        .store_r_we_o(r_we), .store_r_addr_o(r_addr),
        .store_r_wdata_o(r_wdata), .store_r_rdata_i(r_rdata),
        .mac_valid_o(mac_valid), .mac_first_o(mac_first), .mac_last_o(mac_last),
        .mac_a_o(mac_a), .mac_b_o(mac_b),
        .mac_result_i(mac_result), .mac_result_valid_i(mac_result_valid)
    );

    word_assembler #(.RX_TIMEOUT_CYCLES(RX_TIMEOUT_CYCLES)) u_assembler (
        .CLK100MHZ(CLK100MHZ), .reset_i(reset_i),
        .rx_byte_i(rx_byte_i), .rx_valid_i(rx_valid_i), .expect_i(word_expect),
        .word_o(word), .word_valid_o(word_valid), .timeout_o(rx_timeout)
    );

    word_serializer u_serializer (
        .CLK100MHZ(CLK100MHZ), .reset_i(reset_i),
        .req_i(send_req), .word_i(send_word), .is_word_i(send_is_word),
        .done_o(send_done),
        .tx_byte_o(tx_byte_o), .tx_valid_o(tx_valid_o), .tx_ready_i(tx_ready_i)
    );

    matrix_store #(.MAX_DIM(MAX_DIM)) u_store_a (
        .CLK100MHZ(CLK100MHZ), .we_i(a_we), .addr_i(a_addr),
        .wdata_i(a_wdata), .rdata_o(a_rdata)
    );

    matrix_store #(.MAX_DIM(MAX_DIM)) u_store_b (
        .CLK100MHZ(CLK100MHZ), .we_i(b_we), .addr_i(b_addr),
        .wdata_i(b_wdata), .rdata_o(b_rdata)
    );

    matrix_store #(.MAX_DIM(MAX_DIM)) u_store_r (
        .CLK100MHZ(CLK100MHZ), .we_i(r_we), .addr_i(r_addr),
        .wdata_i(r_wdata), .rdata_o(r_rdata)
    );

    mac_unit u_mac (
        .CLK100MHZ(CLK100MHZ), .reset_i(reset_i),
        .valid_i(mac_valid), .first_i(mac_first), .last_i(mac_last),
        .a_i(mac_a), .b_i(mac_b),
        .result_o(mac_result), .result_valid_o(mac_result_valid)
    );

endmodule

`default_nettype wire

// File: rtl/word_assembler.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Four bytes in, one word out, MSB first. No back-pressure on receive
// Timeout counts idle cycles only while expect_i is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module word_assembler
    import mma_proto_pkg::*;
#(
    parameter int RX_TIMEOUT_CYCLES = 2000
) (
    input  logic  CLK100MHZ,
    input  logic  reset_i,
    input  byte_t rx_byte_i,
    input  logic  rx_valid_i,
    input  logic  expect_i,
    output word_t word_o,
    output logic  word_valid_o,
    output logic  timeout_o
);

    localparam int TW = $clog2(RX_TIMEOUT_CYCLES + 1);

    word_t         shift_q;                     // Partial word
    logic [1:0]    cnt;                         // Bytes held so far
    logic [TW-1:0] idle_cnt;

    always_ff @(posedge CLK100MHZ) begin
        if (reset_i) begin
            cnt          <= '0;
            idle_cnt     <= '0;
            word_valid_o <= 1'b0;
            timeout_o    <= 1'b0;
        end else begin
            word_valid_o <= 1'b0;
            timeout_o    <= 1'b0;
            if (!expect_i) begin                // Sequencer not listening
                cnt      <= '0;
                idle_cnt <= '0;
            end else if (rx_valid_i) begin
                shift_q      <= {shift_q[23:0], rx_byte_i};
                cnt          <= cnt + 2'd1;     // Wraps after the fourth byte
                idle_cnt     <= '0;
                word_valid_o <= (cnt == 2'd3);
            end else if (idle_cnt == TW'(RX_TIMEOUT_CYCLES - 1)) begin
                timeout_o <= 1'b1;
                idle_cnt  <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    assign word_o = shift_q;

endmodule

`default_nettype wire

// File: rtl/word_serializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sends a word as four bytes MSB first, or a single code byte
// Requester must hold req_i until done_o
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module word_serializer
    import mma_proto_pkg::*;
(
    input  logic  CLK100MHZ,
    input  logic  reset_i,
    input  logic  req_i,
    input  word_t word_i,
    input  logic  is_word_i,
    output logic  done_o,
    output byte_t tx_byte_o,
    output logic  tx_valid_o,
    input  logic  tx_ready_i
);

    word_t      data_q;                         // Current byte sits in the top
    logic [1:0] left;                           // Bytes after the current one

    always_ff @(posedge CLK100MHZ) begin
        if (reset_i) begin
            tx_valid_o <= 1'b0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (tx_valid_o) begin
                if (tx_ready_i) begin           // Byte taken
                    if (left == '0) begin
                        tx_valid_o <= 1'b0;
                        done_o     <= 1'b1;
                    end else begin
                        left   <= left - 2'd1;
                        data_q <= {data_q[23:0], 8'h00};
                    end
                end
            end else if (req_i && !done_o) begin // Old request still high in done cycle
                tx_valid_o <= 1'b1;
                data_q     <= is_word_i ? word_i : {word_i[7:0], 24'h0};
                left       <= is_word_i ? 2'd3 : 2'd0;
            end
        end
    end

    assign tx_byte_o = data_q[31:24];

endmodule

`default_nettype wire

// File: vlog.f
+incdir+bench
rtl/mma_proto_pkg.sv
rtl/mma_core_pkg.sv
rtl/matrix_store.sv
rtl/mac_unit.sv
rtl/word_assembler.sv
rtl/word_serializer.sv
rtl/mma_sequencer.sv
rtl/mma_top.sv
bench/tb_mma.sv
